//--- logic/chdr_pkg.sv
// CHDR packet definitions for the block shell
// Header and settings-write word layouts, stream word and packet classes

`default_nettype none

package chdr_pkg;

   // Header word as it sits on the wire, type bits at the top
   typedef struct packed {
      logic [1:0]  pkt_type;
      logic        has_time;
      logic        eob;
      logic [11:0] seqnum;
      logic [15:0] length;
      logic [15:0] src_sid;
      logic [15:0] dst_sid;
   } chdr_hdr_t;

   // First payload word of a command packet
   typedef struct packed {
      logic [23:0] reserved;
      logic [7:0]  addr;
      logic [31:0] data;
   } sr_write_t;

   // Word 0 of a command reads as a header, word 1 as a settings write
   typedef union packed {
      chdr_hdr_t hdr;
      sr_write_t wr;
   } chdr_word_u;

   typedef struct packed {
      logic [63:0] tdata;
      logic        tlast;
   } axis_word_t;

   typedef enum logic [1:0] {
      CLASS_DATA,
      CLASS_CMD,
      CLASS_DROP
   } pkt_class_e;

   // Type codes are {hdr[63:62], hdr[60]}
   localparam logic [2:0] PKT_DATA     = 3'd0;
   localparam logic [2:0] PKT_DATA_EOB = 3'd1;
   localparam logic [2:0] PKT_FC_RESP  = 3'd2;
   localparam logic [2:0] PKT_FC_ACK   = 3'd3;
   localparam logic [2:0] PKT_CMD      = 3'd4;
   localparam logic [2:0] PKT_CMD_EOB  = 3'd5;
   localparam logic [2:0] PKT_RESP     = 3'd6;
   localparam logic [2:0] PKT_RESP_ERR = 3'd7;

   // Two 64-bit words per response
   localparam logic [15:0] RESP_LENGTH = 16'd16;

endpackage

`default_nettype wire

//--- logic/shell_regs_pkg.sv
// Block shell register map
// Settings addresses, readback selectors and identity constants

`default_nettype none

package shell_regs_pkg;

   typedef struct packed {
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // Readback sources with codes 2, 3 and 7 left unused
   typedef enum logic [2:0] {
      RB_NOC_ID        = 3'd0,
      RB_GLOBAL_PARAMS = 3'd1,
      RB_BLOCK_SIDS    = 3'd4,
      RB_USER_DATA     = 3'd5,
      RB_COMPAT_NUM    = 3'd6
   } rb_sel_e;

   ////////////////////////////////////////////////////////////
   // Settings bus addresses
   ////////////////////////////////////////////////////////////
   localparam logic [7:0] SR_SRC_SID      = 8'd1;
   localparam logic [7:0] SR_NEXT_DST_SID = 8'd2;
   localparam logic [7:0] SR_RB_ADDR      = 8'd124;
   localparam logic [7:0] SR_RB_ADDR_USER = 8'd125;

   ////////////////////////////////////////////////////////////
   // Identity
   ////////////////////////////////////////////////////////////
   localparam logic [63:0] NOC_ID       = 64'hDEAD_BEEF_0123_4567;
   localparam logic [31:0] COMPAT_MAJOR = 32'd5;
   localparam logic [31:0] COMPAT_MINOR = 32'd0;
   localparam logic [63:0] BAD_READBACK = 64'h0BAD_C0DE_0BAD_C0DE;
   localparam logic [4:0]  NUM_PORTS    = 5'd1;

endpackage

`default_nettype wire

//--- logic/pkt_type_router.sv
// Inbound packet router
// Classes each packet from its header and steers words to sink, command path or drop

`timescale 1ns/1ns
`default_nettype none

module pkt_type_router import chdr_pkg::*; (
   input  wire             clk,
   input  wire             reset,
   input  wire axis_word_t i_in,
   input  wire             i_in_valid,
   output logic            o_in_ready,
   output axis_word_t      o_sink,
   output logic            o_sink_valid,
   input  wire             i_sink_ready,
   output axis_word_t      o_cmd,
   output logic            o_cmd_valid,
   input  wire             i_cmd_ready,
   output logic            o_data_pkt_done
);

   logic       first_q;
   pkt_class_e class_q;
   pkt_class_e hdr_class;
   pkt_class_e cur_class;
   chdr_hdr_t  hdr;
   logic [2:0] type_code;
   logic       in_xfer;

   assign hdr       = i_in.tdata;
   assign type_code = {hdr.pkt_type, hdr.eob};

   // FC ACK stays in line with data
   always_comb begin
      case (type_code)
         PKT_DATA, PKT_DATA_EOB, PKT_FC_ACK: hdr_class = CLASS_DATA;
         PKT_CMD, PKT_CMD_EOB:               hdr_class = CLASS_CMD;
         default:                            hdr_class = CLASS_DROP;
      endcase
   end

   // Header word decides on the spot, later words use the held class
   assign cur_class = first_q ? hdr_class : class_q;

   always_comb begin
      case (cur_class)
         CLASS_DATA: o_in_ready = i_sink_ready;
         CLASS_CMD:  o_in_ready = i_cmd_ready;
         default:    o_in_ready = 1'b1;
      endcase
   end

   assign in_xfer = i_in_valid & o_in_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         first_q <= 1'b1;
         class_q <= CLASS_DATA;
      end else if (in_xfer) begin
         first_q <= i_in.tlast;
         if (first_q) begin
            class_q <= hdr_class;
         end
      end
   end

   assign o_sink          = i_in;
   assign o_sink_valid    = i_in_valid & (cur_class == CLASS_DATA);
   assign o_cmd           = i_in;
   assign o_cmd_valid     = i_in_valid & (cur_class == CLASS_CMD);
   assign o_data_pkt_done = o_sink_valid & i_sink_ready & i_in.tlast;

   // Mid-packet the class must not move
   a_class_held : assert property (@(posedge clk) disable iff (reset)
      !first_q && $past(!first_q) |-> $stable(class_q));

endmodule

`default_nettype wire

//--- logic/cmd_proc_fsm.sv
// Command packet processor
// Turns each command into one settings write and sends back a two-word response

`timescale 1ns/1ns
`default_nettype none

module cmd_proc_fsm import chdr_pkg::*, shell_regs_pkg::*; (
   input  wire             clk,
   input  wire             reset,
   input  wire axis_word_t i_cmd,
   input  wire             i_cmd_valid,
   output logic            o_cmd_ready,
   output logic            o_set_stb,
   output set_bus_t        o_set,
   input  wire             i_rb_valid,
   input  wire [63:0]      i_rb_data,
   output axis_word_t      o_resp,
   output logic            o_resp_valid,
   input  wire             i_resp_ready,
   output logic            o_cmd_done
);

   typedef enum logic [2:0] {
      HEADER,
      PAYLOAD,
      DRAIN,
      SETTING,
      READBACK,
      RESP_HDR,
      RESP_DATA
   } state_e;

   state_e      state;
   chdr_word_u  in_word;
   chdr_hdr_t   resp_hdr;
   logic [11:0] seqnum_q;
   logic [15:0] src_sid_q;
   logic [15:0] dst_sid_q;
   set_bus_t    set_q;
   logic [63:0] rb_data_q;
   logic        cmd_xfer;
   logic        resp_xfer;

   assign in_word   = i_cmd.tdata;
   assign cmd_xfer  = i_cmd_valid & o_cmd_ready;
   assign resp_xfer = o_resp_valid & i_resp_ready;

   ////////////////////////////////////////////////////////////
   // State machine
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= HEADER;
      end else begin
         case (state)
            // A header-only packet has nothing to write and is dropped
            HEADER: if (cmd_xfer && !i_cmd.tlast) state <= PAYLOAD;
            PAYLOAD: if (cmd_xfer) state <= i_cmd.tlast ? SETTING : DRAIN;
            DRAIN: if (cmd_xfer && i_cmd.tlast) state <= SETTING;
            SETTING: state <= READBACK;
            READBACK: if (i_rb_valid) state <= RESP_HDR;
            RESP_HDR: if (resp_xfer) state <= RESP_DATA;
            RESP_DATA: if (resp_xfer) state <= HEADER;
            default: state <= HEADER;
         endcase
      end
   end

   // Saved fields for the write and the reply
   always_ff @(posedge clk) begin
      if (state == HEADER && cmd_xfer) begin
         seqnum_q  <= in_word.hdr.seqnum;
         src_sid_q <= in_word.hdr.src_sid;
         dst_sid_q <= in_word.hdr.dst_sid;
      end
      if (state == PAYLOAD && cmd_xfer) begin
         set_q.addr <= in_word.wr.addr;
         set_q.data <= in_word.wr.data;
      end
      if (state == READBACK && i_rb_valid) begin
         rb_data_q <= i_rb_data;
      end
   end

   assign o_cmd_ready = (state == HEADER) || (state == PAYLOAD) || (state == DRAIN);
   assign o_set_stb   = (state == SETTING);
   assign o_set       = set_q;

   ////////////////////////////////////////////////////////////
   // Response
   ////////////////////////////////////////////////////////////
   // Stream IDs swap so the reply goes back to the sender
   always_comb begin
      resp_hdr          = '0;
      resp_hdr.pkt_type = PKT_RESP[2:1];
      resp_hdr.eob      = PKT_RESP[0];
      resp_hdr.seqnum   = seqnum_q;
      resp_hdr.length   = RESP_LENGTH;
      resp_hdr.src_sid  = dst_sid_q;
      resp_hdr.dst_sid  = src_sid_q;
   end

   assign o_resp.tdata = (state == RESP_DATA) ? rb_data_q : resp_hdr;
   assign o_resp.tlast = (state == RESP_DATA);
   assign o_resp_valid = (state == RESP_HDR) || (state == RESP_DATA);
   assign o_cmd_done   = resp_xfer & (state == RESP_DATA);

   a_set_stb_single : assert property (@(posedge clk) disable iff (reset)
      o_set_stb |=> !o_set_stb);

   a_resp_stable : assert property (@(posedge clk) disable iff (reset)
      o_resp_valid && !i_resp_ready |=> o_resp_valid && $stable(o_resp));

endmodule

`default_nettype wire

//--- logic/traffic_counters.sv
// Traffic counters
// Wrapping counts of delivered data packets and finished commands

`timescale 1ns/1ns
`default_nettype none

module traffic_counters (
   input  wire         clk,
   input  wire         reset,
   input  wire         i_data_pkt_done,
   input  wire         i_cmd_done,
   output logic [15:0] o_data_pkt_cnt,
   output logic [15:0] o_cmd_cnt
);

   // Data packets seen on the sink
   always_ff @(posedge clk) begin
      if (reset) begin
         o_data_pkt_cnt <= 16'd0;
      end else if (i_data_pkt_done) begin
         o_data_pkt_cnt <= o_data_pkt_cnt + 16'd1;
      end
   end

   // Commands whose response has left
   always_ff @(posedge clk) begin
      if (reset) begin
         o_cmd_cnt <= 16'd0;
      end else if (i_cmd_done) begin
         o_cmd_cnt <= o_cmd_cnt + 16'd1;
      end
   end

endmodule

`default_nettype wire

//--- logic/shell_settings.sv
// Shell settings registers and readback mux
// Stream IDs, readback selectors and the registered readback word

`timescale 1ns/1ns
`default_nettype none

module shell_settings import shell_regs_pkg::*; (
   input  wire           clk,
   input  wire           reset,
   input  wire           i_set_stb,
   input  wire set_bus_t i_set,
   input  wire [15:0]    i_data_pkt_cnt,
   input  wire [15:0]    i_cmd_cnt,
   output logic [7:0]    o_rb_addr,
   input  wire           i_rb_stb,
   input  wire [63:0]    i_rb_data,
   output logic          o_rb_valid,
   output logic [63:0]   o_rb_data
);

   logic [15:0] src_sid_q;
   logic [15:0] next_dst_sid_q;
   rb_sel_e     rb_sel_q;

   ////////////////////////////////////////////////////////////
   // Settings registers
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         src_sid_q      <= 16'd0;
         next_dst_sid_q <= 16'd0;
         rb_sel_q       <= RB_NOC_ID;
         o_rb_addr      <= 8'd0;
      end else if (i_set_stb) begin
         case (i_set.addr)
            SR_SRC_SID:      src_sid_q      <= i_set.data[15:0];
            SR_NEXT_DST_SID: next_dst_sid_q <= i_set.data[15:0];
            // Unlisted codes are kept and read back as BAD_READBACK
            SR_RB_ADDR:      rb_sel_q       <= rb_sel_e'(i_set.data[2:0]);
            SR_RB_ADDR_USER: o_rb_addr      <= i_set.data[7:0];
            default:         ;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Readback mux
   ////////////////////////////////////////////////////////////
   // A write clears valid so the next value seen reflects it
   always_ff @(posedge clk) begin
      if (reset) begin
         o_rb_valid <= 1'b0;
      end else if (i_set_stb) begin
         o_rb_valid <= 1'b0;
      end else begin
         o_rb_valid <= (rb_sel_q == RB_USER_DATA) ? i_rb_stb : 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      case (rb_sel_q)
         RB_NOC_ID: o_rb_data <= NOC_ID;
         RB_GLOBAL_PARAMS: begin
            o_rb_data <= {i_data_pkt_cnt, i_cmd_cnt, 16'd0,
                          3'd0, NUM_PORTS, 3'd0, NUM_PORTS};
         end
         RB_BLOCK_SIDS: o_rb_data <= {src_sid_q, next_dst_sid_q, 32'd0};
         RB_USER_DATA: begin
            if (i_rb_stb) begin
               o_rb_data <= i_rb_data;
            end
         end
         RB_COMPAT_NUM: o_rb_data <= {COMPAT_MAJOR, COMPAT_MINOR};
         default: o_rb_data <= BAD_READBACK;
      endcase
   end

   a_no_stale_rb : assert property (@(posedge clk) disable iff (reset)
      i_set_stb |=> !o_rb_valid);

endmodule

`default_nettype wire

//--- logic/noc_shell_lite.sv
// Single-port block shell top
// Router, command processor, traffic counters and settings registers

`timescale 1ns/1ns
`default_nettype none

module noc_shell_lite import chdr_pkg::*, shell_regs_pkg::*; (
   input  wire             clk,
   input  wire             reset,
   input  wire axis_word_t i_in,
   input  wire             i_in_valid,
   output logic            o_in_ready,
   output axis_word_t      o_sink,
   output logic            o_sink_valid,
   input  wire             i_sink_ready,
   output axis_word_t      o_resp,
   output logic            o_resp_valid,
   input  wire             i_resp_ready,
   output logic            o_set_stb,
   output set_bus_t        o_set,
   output logic [7:0]      o_rb_addr,
   input  wire             i_rb_stb,
   input  wire [63:0]      i_rb_data
);

   axis_word_t  cmd;
   logic        cmd_valid;
   logic        cmd_ready;
   logic        data_pkt_done;
   logic        cmd_done;
   logic        rb_valid;
   logic [63:0] rb_data;
   logic [15:0] data_pkt_cnt;
   logic [15:0] cmd_cnt;

   pkt_type_router router0 (
      .clk             (clk),
      .reset           (reset),
      .i_in            (i_in),
      .i_in_valid      (i_in_valid),
      .o_in_ready      (o_in_ready),
      .o_sink          (o_sink),
      .o_sink_valid    (o_sink_valid),
      .i_sink_ready    (i_sink_ready),
      .o_cmd           (cmd),
      .o_cmd_valid     (cmd_valid),
      .i_cmd_ready     (cmd_ready),
      .o_data_pkt_done (data_pkt_done)
   );

   cmd_proc_fsm cmd0 (
      .clk          (clk),
      .reset        (reset),
      .i_cmd        (cmd),
      .i_cmd_valid  (cmd_valid),
      .o_cmd_ready  (cmd_ready),
      .o_set_stb    (o_set_stb),
      .o_set        (o_set),
      .i_rb_valid   (rb_valid),
      .i_rb_data    (rb_data),
      .o_resp       (o_resp),
      .o_resp_valid (o_resp_valid),
      .i_resp_ready (i_resp_ready),
      .o_cmd_done   (cmd_done)
   );

   traffic_counters cnt0 (
      .clk             (clk),
      .reset           (reset),
      .i_data_pkt_done (data_pkt_done),
      .i_cmd_done      (cmd_done),
      .o_data_pkt_cnt  (data_pkt_cnt),
      .o_cmd_cnt       (cmd_cnt)
   );

   shell_settings regs0 (
      .clk            (clk),
      .reset          (reset),
      .i_set_stb      (o_set_stb),
      .i_set          (o_set),
      .i_data_pkt_cnt (data_pkt_cnt),
      .i_cmd_cnt      (cmd_cnt),
      .o_rb_addr      (o_rb_addr),
      .i_rb_stb       (i_rb_stb),
      .i_rb_data      (i_rb_data),
      .o_rb_valid     (rb_valid),
      .o_rb_data      (rb_data)
   );

endmodule

`default_nettype wire

//--- dv/shell_model.svh
// Reference model of the block shell
// Packet classes, register and counter state, expected readback and response header

`ifndef SHELL_MODEL_SVH
`define SHELL_MODEL_SVH

// Register and counter state as seen after each command
logic [15:0] m_src_sid;
logic [15:0] m_next_dst_sid;
logic [2:0]  m_rb_sel;
logic [7:0]  m_rb_addr;
logic [15:0] m_data_cnt;
logic [15:0] m_cmd_cnt;

function void reset_model();
   m_src_sid      = 16'd0;
   m_next_dst_sid = 16'd0;
   m_rb_sel       = 3'd0;
   m_rb_addr      = 8'd0;
   m_data_cnt     = 16'd0;
   m_cmd_cnt      = 16'd0;
endfunction

function automatic pkt_class_e expected_class(input logic [2:0] type_code);
   case (type_code)
      PKT_DATA, PKT_DATA_EOB, PKT_FC_ACK: return CLASS_DATA;
      PKT_CMD, PKT_CMD_EOB:               return CLASS_CMD;
      default:                            return CLASS_DROP;
   endcase
endfunction

// User readback data is the address repeated across the word and XORed with a mask
function automatic logic [63:0] user_rule(input logic [7:0] addr);
   return {8{addr}} ^ 64'h5A5A_0F0F_C3C3_9696;
endfunction

function void apply_write(input logic [7:0] addr, input logic [31:0] data);
   case (addr)
      SR_SRC_SID:      m_src_sid      = data[15:0];
      SR_NEXT_DST_SID: m_next_dst_sid = data[15:0];
      SR_RB_ADDR:      m_rb_sel       = data[2:0];
      SR_RB_ADDR_USER: m_rb_addr      = data[7:0];
      default:         ;
   endcase
endfunction

function automatic logic [63:0] expected_readback();
   case (m_rb_sel)
      3'd0:    return NOC_ID;
      3'd1:    return {m_data_cnt, m_cmd_cnt, 16'd0, 3'b000, NUM_PORTS, 3'b000, NUM_PORTS};
      3'd4:    return {m_src_sid, m_next_dst_sid, 32'd0};
      3'd5:    return user_rule(m_rb_addr);
      3'd6:    return {COMPAT_MAJOR, COMPAT_MINOR};
      default: return BAD_READBACK;
   endcase
endfunction

// Reply goes back to the sender with the same sequence number
function automatic logic [63:0] expected_resp_hdr(input chdr_hdr_t cmd);
   chdr_hdr_t h;
   h          = '0;
   h.pkt_type = PKT_RESP[2:1];
   h.eob      = PKT_RESP[0];
   h.seqnum   = cmd.seqnum;
   h.length   = RESP_LENGTH;
   h.src_sid  = cmd.dst_sid;
   h.dst_sid  = cmd.src_sid;
   return h;
endfunction

`endif

//--- dv/tb_noc_shell_lite.sv
// Testbench for the single-port block shell
// Random data, dropped and command packets checked against a reference model

`timescale 1ns/1ns
`default_nettype none

module tb_noc_shell_lite import chdr_pkg::*, shell_regs_pkg::*;;

   localparam int N_DATA_PKTS    = 24;
   localparam int N_DROP_ROUNDS  = 6;
   localparam int N_CMDS         = 13;
   localparam int MAX_LEN        = 8;
   localparam int N_PKTS         = N_DATA_PKTS + 4 * N_DROP_ROUNDS + 4 + N_CMDS;
   localparam int TIMEOUT_CYCLES = N_PKTS * MAX_LEN * 20;

   logic        clk;
   logic        reset;
   axis_word_t  i_in;
   logic        i_in_valid;
   logic        o_in_ready;
   axis_word_t  o_sink;
   logic        o_sink_valid;
   logic        i_sink_ready;
   axis_word_t  o_resp;
   logic        o_resp_valid;
   logic        i_resp_ready;
   logic        o_set_stb;
   set_bus_t    o_set;
   logic [7:0]  o_rb_addr;
   logic        i_rb_stb;
   logic [63:0] i_rb_data;

   integer      seed;
   logic [31:0] bp_rnd;
   logic [11:0] seqnum;
   int          errors;
   int          checks;
   axis_word_t  sink_q[$];
   axis_word_t  resp_q[$];
   set_bus_t    set_q[$];

   `include "shell_model.svh"

   noc_shell_lite dut0 (
      .clk          (clk),
      .reset        (reset),
      .i_in         (i_in),
      .i_in_valid   (i_in_valid),
      .o_in_ready   (o_in_ready),
      .o_sink       (o_sink),
      .o_sink_valid (o_sink_valid),
      .i_sink_ready (i_sink_ready),
      .o_resp       (o_resp),
      .o_resp_valid (o_resp_valid),
      .i_resp_ready (i_resp_ready),
      .o_set_stb    (o_set_stb),
      .o_set        (o_set),
      .o_rb_addr    (o_rb_addr),
      .i_rb_stb     (i_rb_stb),
      .i_rb_data    (i_rb_data)
   );

   always #4 clk = ~clk;

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////
   task check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      end
   endtask

   function automatic int rand_len();
      logic [31:0] r;
      r = $random(seed);
      return 1 + (int'(r[7:0]) % MAX_LEN);
   endfunction

   function automatic chdr_hdr_t make_header(input logic [2:0] tc, input logic [11:0] seq,
                                              input logic [15:0] len, input logic [15:0] src,
                                              input logic [15:0] dst);
      chdr_hdr_t h;
      h          = '0;
      h.pkt_type = tc[2:1];
      h.eob      = tc[0];
      h.seqnum   = seq;
      h.length   = len;
      h.src_sid  = src;
      h.dst_sid  = dst;
      return h;
   endfunction

   // Called on a falling edge, returns on the falling edge after the transfer
   task send_word(input axis_word_t w);
      i_in       = w;
      i_in_valid = 1'b1;
      @(posedge clk);
      while (!o_in_ready) @(posedge clk);
      @(negedge clk);
      i_in_valid = 1'b0;
   endtask

   task send_pkt(input logic [2:0] tc, input int nwords);
      axis_word_t w;
      pkt_class_e cls;
      cls = expected_class(tc);
      for (int i = 0; i < nwords; i++) begin
         if (i == 0) begin
            w.tdata = make_header(tc, seqnum, 16'(nwords * 8), 16'h0010, 16'h0020);
         end else begin
            w.tdata = {$random(seed), $random(seed)};
         end
         w.tlast = (i == nwords - 1);
         if (cls == CLASS_DATA) begin
            sink_q.push_back(w);
         end
         send_word(w);
      end
      seqnum++;
      if (cls == CLASS_DATA) begin
         m_data_cnt++;
      end
   endtask

   // Waits for the reply so the counters are settled before the next packet
   task send_cmd(input logic [7:0] addr, input logic [31:0] data, input int extra);
      chdr_hdr_t  hdr;
      sr_write_t  wr;
      axis_word_t w;
      hdr = make_header(extra[0] ? PKT_CMD_EOB : PKT_CMD, seqnum, 16'((2 + extra) * 8),
                        {4'h1, seqnum}, {4'h2, seqnum});
      seqnum++;
      wr      = '0;
      wr.addr = addr;
      wr.data = data;
      set_q.push_back({addr, data});
      apply_write(addr, data);
      resp_q.push_back({expected_resp_hdr(hdr), 1'b0});
      resp_q.push_back({expected_readback(), 1'b1});
      m_cmd_cnt++;
      w.tdata = hdr;
      w.tlast = 1'b0;
      send_word(w);
      w.tdata = wr;
      w.tlast = (extra == 0);
      send_word(w);
      for (int i = 0; i < extra; i++) begin
         w.tdata = {$random(seed), $random(seed)};
         w.tlast = (i == extra - 1);
         send_word(w);
      end
      while (resp_q.size() != 0) @(negedge clk);
      check_value("o_rb_addr", o_rb_addr, m_rb_addr);
   endtask

   ////////////////////////////////////////////////////////////
   // Back-pressure and user readback
   ////////////////////////////////////////////////////////////
   always @(negedge clk) begin
      bp_rnd       = $random(seed);
      i_sink_ready = bp_rnd[0] | bp_rnd[1];
      i_resp_ready = bp_rnd[2];
      i_rb_stb     = bp_rnd[3] & bp_rnd[4];
      i_rb_data    = user_rule(o_rb_addr);
   end

   ////////////////////////////////////////////////////////////
   // Output checkers
   ////////////////////////////////////////////////////////////
   always @(posedge clk) begin
      axis_word_t exp;
      if (!reset && o_sink_valid && i_sink_ready) begin
         if (sink_q.size() == 0) begin
            errors++;
            $display("A word appeared on o_sink when no data packet was pending");
         end else begin
            exp = sink_q.pop_front();
            check_value("o_sink.tdata", o_sink.tdata, exp.tdata);
            check_value("o_sink.tlast", o_sink.tlast, exp.tlast);
         end
      end
   end

   always @(posedge clk) begin
      axis_word_t exp;
      if (!reset && o_resp_valid && i_resp_ready) begin
         if (resp_q.size() == 0) begin
            errors++;
            $display("A word appeared on o_resp when no response was pending");
         end else begin
            exp = resp_q.pop_front();
            check_value("o_resp.tdata", o_resp.tdata, exp.tdata);
            check_value("o_resp.tlast", o_resp.tlast, exp.tlast);
         end
      end
   end

   always @(posedge clk) begin
      set_bus_t exp;
      if (!reset && o_set_stb) begin
         if (set_q.size() == 0) begin
            errors++;
            $display("A settings write appeared on o_set with no command pending");
         end else begin
            exp = set_q.pop_front();
            check_value("o_set", o_set, exp);
         end
      end
   end

   // Bound from packet count and longest packet
   initial begin
      #(TIMEOUT_CYCLES * 8);
      errors++;
      $display("Timeout: the test did not complete within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("Finished with errors");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////
   initial begin
      logic [2:0] tc;
      seed   = 99;
      errors = 0;
      checks = 0;
      seqnum = 12'd0;
      reset_model();
      clk          = 1'b0;
      reset        = 1'b1;
      i_in         = '0;
      i_in_valid   = 1'b0;
      i_sink_ready = 1'b0;
      i_resp_ready = 1'b0;
      i_rb_stb     = 1'b0;
      i_rb_data    = 64'd0;
      repeat (3) @(negedge clk);
      reset = 1'b0;

      // Sink traffic of random length
      for (int i = 0; i < N_DATA_PKTS; i++) begin
         tc = (i % 3 == 0) ? PKT_DATA : (i % 3 == 1) ? PKT_DATA_EOB : PKT_FC_ACK;
         send_pkt(tc, rand_len());
      end

      // Dropped classes mixed with data
      for (int i = 0; i < N_DROP_ROUNDS; i++) begin
         send_pkt(PKT_FC_RESP, rand_len());
         send_pkt(PKT_RESP, rand_len());
         send_pkt(PKT_RESP_ERR, rand_len());
         send_pkt(PKT_DATA, rand_len());
      end

      // Stream IDs then their readback
      send_cmd(SR_SRC_SID, 32'h0000_1A2B, 0);
      send_cmd(SR_NEXT_DST_SID, 32'hFFFF_3C4D, 0);
      send_cmd(SR_RB_ADDR, {29'd0, RB_BLOCK_SIDS}, 0);

      // Identity readbacks from commands with extra words to drain
      send_cmd(SR_RB_ADDR, {29'd0, RB_NOC_ID}, 1);
      send_cmd(SR_RB_ADDR, {29'd0, RB_COMPAT_NUM}, 2);
      send_cmd(SR_RB_ADDR, 32'd2, 0);
      send_cmd(SR_RB_ADDR, 32'd7, 3);

      // Traffic counts
      send_cmd(SR_RB_ADDR, {29'd0, RB_GLOBAL_PARAMS}, 0);
      for (int i = 0; i < 4; i++) begin
         send_pkt(PKT_DATA_EOB, rand_len());
      end
      send_cmd(8'd50, 32'h1234_5678, 0);

      // User readback with varying latency
      send_cmd(SR_RB_ADDR_USER, 32'h0000_003C, 0);
      send_cmd(SR_RB_ADDR, {29'd0, RB_USER_DATA}, 0);
      send_cmd(SR_RB_ADDR_USER, 32'h0000_00A5, 1);
      send_cmd(SR_RB_ADDR_USER, 32'h0000_0007, 0);

      while (sink_q.size() != 0 || resp_q.size() != 0 || set_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (10) @(posedge clk);

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
+incdir+dv
logic/chdr_pkg.sv
logic/shell_regs_pkg.sv
logic/pkt_type_router.sv
logic/cmd_proc_fsm.sv
logic/traffic_counters.sv
logic/shell_settings.sv
logic/noc_shell_lite.sv
dv/tb_noc_shell_lite.sv
